// ==== include/cnn_params.svh ====
`ifndef CNN_PARAMS_SVH
`define CNN_PARAMS_SVH

// even image width and height
`define CNN_IMG_W 8
`define CNN_IMG_H 8

// 9 weights, 3 bias bytes, 4 scale bytes
`define CNN_PARAM_BYTES 16

// ingress depth and the source's credits after reset
`define CNN_IN_DEPTH 4

`define CNN_OUT_CREDITS_MAX 8

// right shift after the scale multiply
`define CNN_QUANT_SHIFT 16

`endif

// ==== rtl/cnn_pkg.sv ====
`default_nettype none

package cnn_pkg;

    // input pixel and quantized output byte
    typedef logic [7:0] pixel_t;

    typedef logic signed [7:0] weight_t;

    // nine 17-bit products fit in 20 bits
    typedef logic signed [19:0] acc_t;

    typedef logic signed [23:0] bias_t;
    typedef logic [31:0] scale_t;

    // row and column run up to the padding index
    typedef logic [3:0] coord_t;

    typedef logic [3:0] credit_t;

    typedef enum logic [1:0] {
        LOAD_PARAMS,
        STREAM,
        DRAIN
    } ctrl_state_t;

endpackage

`default_nettype wire

// ==== rtl/ingress_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cnn_params.svh"

module ingress_fifo (
    input  wire        clk_top,
    input  wire        rst_n,
    input  wire  [7:0] in_data,
    input  wire        in_valid,
    input  wire        pop,
    output logic [7:0] head,
    output logic       not_empty,
    output logic       in_credit
);

    localparam int DEPTH = `CNN_IN_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [7:0]       mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_pop;
    logic             full;

    assign full      = (count == CNT_W'(DEPTH));
    assign not_empty = (count != '0);
    assign do_pop    = pop && not_empty;
    assign head      = mem[rd_ptr];

    always_ff @(posedge clk_top) begin
        if (in_valid) begin
            mem[wr_ptr] <= in_data;
        end
    end

    always_ff @(posedge clk_top or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            in_credit <= 1'b0;
        end else begin
            if (in_valid) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count     <= count + CNT_W'(in_valid) - CNT_W'(do_pop);
            // one credit back per byte taken
            in_credit <= do_pop;
        end
    end

    // source must hold its credits, so a full buffer never sees a push
    no_overrun: assert property (@(posedge clk_top) disable iff (!rst_n)
        in_valid |-> !full);

endmodule

`default_nettype wire

// ==== rtl/param_loader.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cnn_params.svh"

module param_loader (
    input  wire                    clk_top,
    input  wire                    rst_n,
    input  wire                    load,
    input  wire  cnn_pkg::pixel_t  byte_in,
    output cnn_pkg::weight_t       weights [9],
    output cnn_pkg::bias_t         bias,
    output cnn_pkg::scale_t        scale,
    output logic                   loaded
);

    localparam int BLOCK_W = 8 * `CNN_PARAM_BYTES;
    localparam int CNT_W   = $clog2(`CNN_PARAM_BYTES);

    logic [BLOCK_W-1:0] shift_r;
    logic [BLOCK_W-1:0] param_r;
    logic [CNT_W-1:0]   byte_cnt;

    assign loaded = load && (byte_cnt == CNT_W'(`CNN_PARAM_BYTES - 1));

    // new block goes live only once complete, so windows still in flight
    // keep the old weights, bias and scale
    always_ff @(posedge clk_top) begin
        if (load) begin
            shift_r <= {shift_r[BLOCK_W-9:0], byte_in};
        end
        if (loaded) begin
            param_r <= {shift_r[BLOCK_W-9:0], byte_in};
        end
    end

    always_ff @(posedge clk_top or negedge rst_n) begin
        if (!rst_n) begin
            byte_cnt <= '0;
        end else if (load) begin
            byte_cnt <= loaded ? '0 : byte_cnt + 1'b1;
        end
    end

    // first byte received is the top-left weight
    always_comb begin
        for (int i = 0; i < 9; i++) begin
            weights[i] = param_r[BLOCK_W - 8 - 8 * i +: 8];
        end
    end

    assign bias  = param_r[32 +: 24];
    assign scale = param_r[31:0];

endmodule

`default_nettype wire

// ==== rtl/line_window.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cnn_params.svh"

module line_window (
    input  wire                    clk_top,
    input  wire                    rst_n,
    input  wire                    shift,
    input  wire  cnn_pkg::pixel_t  pix,
    input  wire  cnn_pkg::coord_t  col,
    input  wire  cnn_pkg::coord_t  row,
    output cnn_pkg::pixel_t        win [9],
    output logic                   win_valid
);

    localparam int W     = `CNN_IMG_W;
    localparam int IDX_W = $clog2(W);
    localparam cnn_pkg::coord_t PAD_COL = cnn_pkg::coord_t'(`CNN_IMG_W);

    // previous row and the one before it
    cnn_pkg::pixel_t row1_mem [W];
    cnn_pkg::pixel_t row2_mem [W];

    // columns as top, middle, bottom
    cnn_pkg::pixel_t col_in [3];
    cnn_pkg::pixel_t col_m1 [3];
    cnn_pkg::pixel_t col_m2 [3];

    logic             in_image;
    logic             left_pad;
    logic             emit;
    logic [IDX_W-1:0] col_idx;

    assign in_image = (col != PAD_COL);
    assign left_pad = (col == cnn_pkg::coord_t'(1));
    assign emit     = (row != '0) && (col != '0);
    assign col_idx  = col[IDX_W-1:0];

    // rows above the frame top read as zero
    always_comb begin
        col_in[0] = '0;
        col_in[1] = '0;
        if (in_image && (row >= cnn_pkg::coord_t'(2))) begin
            col_in[0] = row2_mem[col_idx];
        end
        if (in_image && (row != '0)) begin
            col_in[1] = row1_mem[col_idx];
        end
        col_in[2] = pix;
    end

    always_ff @(posedge clk_top) begin
        if (shift) begin
            if (in_image) begin
                row2_mem[col_idx] <= row1_mem[col_idx];
                row1_mem[col_idx] <= pix;
            end
            col_m2 <= col_m1;
            col_m1 <= col_in;
            // window centred one row up and one column left
            if (emit) begin
                for (int r = 0; r < 3; r++) begin
                    win[3 * r]     <= left_pad ? '0 : col_m2[r];
                    win[3 * r + 1] <= col_m1[r];
                    win[3 * r + 2] <= col_in[r];
                end
            end
        end
    end

    always_ff @(posedge clk_top or negedge rst_n) begin
        if (!rst_n) begin
            win_valid <= 1'b0;
        end else begin
            win_valid <= shift && emit;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/conv_mac.sv ====
`timescale 1ns/1ps
`default_nettype none

module conv_mac (
    input  wire                    clk_top,
    input  wire                    rst_n,
    input  wire  cnn_pkg::pixel_t  win [9],
    input  wire                    win_valid,
    input  wire  cnn_pkg::weight_t weights [9],
    output cnn_pkg::acc_t          acc,
    output logic                   acc_valid
);

    // 9-bit unsigned pixel times 8-bit weight
    localparam int PROD_W = 17;

    logic signed [PROD_W-1:0] prod [9];
    logic                     prod_valid;
    cnn_pkg::acc_t            prod_sum;

    always_ff @(posedge clk_top) begin
        if (win_valid) begin
            for (int i = 0; i < 9; i++) begin
                prod[i] <= $signed({1'b0, win[i]}) * weights[i];
            end
        end
    end

    always_comb begin
        prod_sum = '0;
        for (int i = 0; i < 9; i++) begin
            prod_sum = prod_sum + prod[i];
        end
    end

    always_ff @(posedge clk_top) begin
        if (prod_valid) begin
            acc <= prod_sum;
        end
    end

    always_ff @(posedge clk_top or negedge rst_n) begin
        if (!rst_n) begin
            prod_valid <= 1'b0;
            acc_valid  <= 1'b0;
        end else begin
            prod_valid <= win_valid;
            acc_valid  <= prod_valid;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/quantizer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cnn_params.svh"

module quantizer (
    input  wire                    clk_top,
    input  wire                    rst_n,
    input  wire  cnn_pkg::acc_t    acc,
    input  wire                    acc_valid,
    input  wire  cnn_pkg::bias_t   bias,
    input  wire  cnn_pkg::scale_t  scale,
    output cnn_pkg::pixel_t        q,
    output logic                   q_valid
);

    localparam int BIASED_W = 25;
    // scale enters as a 33-bit signed value
    localparam int SCALED_W = BIASED_W + 33;

    logic signed [BIASED_W-1:0] biased;
    logic signed [SCALED_W-1:0] scaled;
    logic signed [SCALED_W-1:0] shifted;

    assign biased  = acc + bias;
    assign scaled  = biased * $signed({1'b0, scale});
    assign shifted = scaled >>> `CNN_QUANT_SHIFT;

    // saturate to 0..255
    always_ff @(posedge clk_top) begin
        if (acc_valid) begin
            if (shifted < 0) begin
                q <= '0;
            end else if (shifted > 255) begin
                q <= 8'hff;
            end else begin
                q <= shifted[7:0];
            end
        end
    end

    always_ff @(posedge clk_top or negedge rst_n) begin
        if (!rst_n) begin
            q_valid <= 1'b0;
        end else begin
            q_valid <= acc_valid;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/maxpool_2x2.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cnn_params.svh"

module maxpool_2x2 (
    input  wire                    clk_top,
    input  wire                    rst_n,
    input  wire  cnn_pkg::pixel_t  q,
    input  wire                    q_valid,
    output cnn_pkg::pixel_t        out_data,
    output logic                   out_valid,
    output logic                   out_last
);

    localparam int HALF_W = `CNN_IMG_W / 2;
    localparam int SLOT_W = $clog2(HALF_W);
    localparam cnn_pkg::coord_t LAST_COL = cnn_pkg::coord_t'(`CNN_IMG_W - 1);
    localparam cnn_pkg::coord_t LAST_ROW = cnn_pkg::coord_t'(`CNN_IMG_H - 1);

    // pair maxima from the even row
    cnn_pkg::pixel_t half_row [HALF_W];
    cnn_pkg::pixel_t pair_r;
    cnn_pkg::pixel_t pair_max;
    cnn_pkg::pixel_t pool_max;
    cnn_pkg::coord_t res_col;
    cnn_pkg::coord_t res_row;
    logic [SLOT_W-1:0] slot;

    assign slot     = res_col[SLOT_W:1];
    assign pair_max = (pair_r > q) ? pair_r : q;
    assign pool_max = (half_row[slot] > pair_max) ? half_row[slot] : pair_max;

    always_ff @(posedge clk_top) begin
        if (q_valid) begin
            if (!res_col[0]) begin
                pair_r <= q;
            end else if (!res_row[0]) begin
                half_row[slot] <= pair_max;
            end else begin
                out_data <= pool_max;
            end
        end
    end

    always_ff @(posedge clk_top or negedge rst_n) begin
        if (!rst_n) begin
            res_col   <= '0;
            res_row   <= '0;
            out_valid <= 1'b0;
            out_last  <= 1'b0;
        end else begin
            out_valid <= q_valid && res_row[0] && res_col[0];
            out_last  <= q_valid && (res_row == LAST_ROW) && (res_col == LAST_COL);
            if (q_valid) begin
                if (res_col == LAST_COL) begin
                    res_col <= '0;
                    res_row <= (res_row == LAST_ROW) ? '0 : res_row + 1'b1;
                end else begin
                    res_col <= res_col + 1'b1;
                end
            end
        end
    end

    // frame end lands on a closing pool only for an even image size
    last_on_pool: assert property (@(posedge clk_top) disable iff (!rst_n)
        out_last |-> out_valid);

endmodule

`default_nettype wire

// ==== rtl/cnn_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cnn_params.svh"

module cnn_top (
    input  wire                    clk_top,
    input  wire                    rst_n,
    input  wire  cnn_pkg::pixel_t  in_data,
    input  wire                    in_valid,
    output logic                   in_credit,
    output cnn_pkg::pixel_t        out_data,
    output logic                   out_last,
    output logic                   out_valid,
    input  wire                    out_credit
);

    localparam cnn_pkg::coord_t  PAD_COL    = cnn_pkg::coord_t'(`CNN_IMG_W);
    localparam cnn_pkg::coord_t  PAD_ROW    = cnn_pkg::coord_t'(`CNN_IMG_H);
    localparam cnn_pkg::coord_t  LAST_ROW   = cnn_pkg::coord_t'(`CNN_IMG_H - 1);
    localparam cnn_pkg::credit_t CREDIT_MAX = cnn_pkg::credit_t'(`CNN_OUT_CREDITS_MAX);

    cnn_pkg::ctrl_state_t state;
    cnn_pkg::coord_t      row;
    cnn_pkg::coord_t      col;
    cnn_pkg::credit_t     credits;
    cnn_pkg::credit_t     in_flight;
    cnn_pkg::pixel_t      head;
    cnn_pkg::pixel_t      pix;
    cnn_pkg::weight_t     weights [9];
    cnn_pkg::bias_t       bias;
    cnn_pkg::scale_t      scale;
    cnn_pkg::pixel_t      win [9];
    cnn_pkg::acc_t        acc;
    cnn_pkg::pixel_t      q;

    logic not_empty;
    logic pop;
    logic load;
    logic loaded;
    logic real_pix;
    logic credit_ok;
    logic advance;
    logic pool_fire;
    logic win_valid;
    logic acc_valid;
    logic q_valid;

    // padding column and the drain row need no input byte
    assign real_pix  = (state == cnn_pkg::STREAM) && (col != PAD_COL);
    assign credit_ok = (credits > in_flight);

    always_comb begin
        case (state)
            cnn_pkg::STREAM: advance = credit_ok && (!real_pix || not_empty);
            cnn_pkg::DRAIN:  advance = credit_ok;
            default:         advance = 1'b0;
        endcase
    end

    assign load = (state == cnn_pkg::LOAD_PARAMS) && not_empty;
    assign pop  = load || (advance && real_pix);
    assign pix  = real_pix ? head : '0;

    // window centre on odd row and odd column closes a pool
    assign pool_fire = advance && (row != '0) && (col != '0) && !row[0] && !col[0];

    always_ff @(posedge clk_top or negedge rst_n) begin
        if (!rst_n) begin
            state <= cnn_pkg::LOAD_PARAMS;
            row   <= '0;
            col   <= '0;
        end else begin
            case (state)
                cnn_pkg::LOAD_PARAMS: begin
                    if (loaded) begin
                        state <= cnn_pkg::STREAM;
                    end
                end
                cnn_pkg::STREAM: begin
                    if (advance && (col == PAD_COL) && (row == LAST_ROW)) begin
                        state <= cnn_pkg::DRAIN;
                    end
                end
                cnn_pkg::DRAIN: begin
                    if (advance && (col == PAD_COL)) begin
                        state <= cnn_pkg::LOAD_PARAMS;
                    end
                end
                default: state <= cnn_pkg::LOAD_PARAMS;
            endcase
            if (advance) begin
                if (col == PAD_COL) begin
                    col <= '0;
                    row <= (row == PAD_ROW) ? '0 : row + 1'b1;
                end else begin
                    col <= col + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk_top or negedge rst_n) begin
        if (!rst_n) begin
            credits   <= '0;
            in_flight <= '0;
        end else begin
            credits   <= credits + cnn_pkg::credit_t'(out_credit)
                                 - cnn_pkg::credit_t'(out_valid);
            in_flight <= in_flight + cnn_pkg::credit_t'(pool_fire)
                                   - cnn_pkg::credit_t'(out_valid);
        end
    end

    ingress_fifo u_ingress_fifo (
        .clk_top   (clk_top),
        .rst_n     (rst_n),
        .in_data   (in_data),
        .in_valid  (in_valid),
        .pop       (pop),
        .head      (head),
        .not_empty (not_empty),
        .in_credit (in_credit)
    );

    param_loader u_param_loader (
        .clk_top (clk_top),
        .rst_n   (rst_n),
        .load    (load),
        .byte_in (head),
        .weights (weights),
        .bias    (bias),
        .scale   (scale),
        .loaded  (loaded)
    );

    line_window u_line_window (
        .clk_top   (clk_top),
        .rst_n     (rst_n),
        .shift     (advance),
        .pix       (pix),
        .col       (col),
        .row       (row),
        .win       (win),
        .win_valid (win_valid)
    );

    conv_mac u_conv_mac (
        .clk_top   (clk_top),
        .rst_n     (rst_n),
        .win       (win),
        .win_valid (win_valid),
        .weights   (weights),
        .acc       (acc),
        .acc_valid (acc_valid)
    );

    quantizer u_quantizer (
        .clk_top   (clk_top),
        .rst_n     (rst_n),
        .acc       (acc),
        .acc_valid (acc_valid),
        .bias      (bias),
        .scale     (scale),
        .q         (q),
        .q_valid   (q_valid)
    );

    maxpool_2x2 u_maxpool_2x2 (
        .clk_top   (clk_top),
        .rst_n     (rst_n),
        .q         (q),
        .q_valid   (q_valid),
        .out_data  (out_data),
        .out_valid (out_valid),
        .out_last  (out_last)
    );

    // sink never grants past the limit
    credit_bound: assert property (@(posedge clk_top) disable iff (!rst_n)
        credits <= CREDIT_MAX);

    // every pooled byte was reserved against a granted credit
    credit_underflow: assert property (@(posedge clk_top) disable iff (!rst_n)
        out_valid |-> (credits != '0) && (in_flight != '0));

endmodule

`default_nettype wire

// ==== testbench/tb_cnn_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cnn_params.svh"

module tb_cnn_top;

    localparam int NPIX        = `CNN_IMG_W * `CNN_IMG_H;
    localparam int FRAME_BYTES = `CNN_PARAM_BYTES + NPIX;
    // identity, random, two saturation frames, back-pressure, two back to back
    localparam int NUM_FRAMES  = 7;
    localparam int CYCLE_LIMIT = 20 * NUM_FRAMES * FRAME_BYTES;

    logic            clk_top;
    logic            rst_n;
    cnn_pkg::pixel_t in_data;
    logic            in_valid;
    logic            in_credit;
    cnn_pkg::pixel_t out_data;
    logic            out_last;
    logic            out_valid;
    logic            out_credit;

    logic [7:0] src_q [$];
    int         exp_data [$];
    int         exp_last [$];
    logic [7:0] prm [`CNN_PARAM_BYTES];
    logic [7:0] img [NPIX];

    integer seed;
    string  cur_test;
    int     errors;
    int     err_start;
    int     tests_run;
    int     tests_failed;
    int     lasts_seen;
    int     lasts_start;
    int     src_credits;
    int     sink_open;
    int     gap;
    int     cycle_count;
    logic   slow_sink;

    cnn_top u_cnn_top (
        .clk_top    (clk_top),
        .rst_n      (rst_n),
        .in_data    (in_data),
        .in_valid   (in_valid),
        .in_credit  (in_credit),
        .out_data   (out_data),
        .out_last   (out_last),
        .out_valid  (out_valid),
        .out_credit (out_credit)
    );

    always #20 clk_top = ~clk_top;

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            errors++;
            $display("mismatch %s %s: expected %0d, actual %0d", cur_test, what,
                     expected, actual);
        end
    endtask

    task automatic flag_error(input string msg);
        errors++;
        $display("error in %s: %s", cur_test, msg);
    endtask

    function automatic int pixel_at(input int y, input int x);
        if (y < 0 || x < 0 || y >= `CNN_IMG_H || x >= `CNN_IMG_W) begin
            return 0;
        end
        return img[y * `CNN_IMG_W + x];
    endfunction

    function automatic void push_expected(input int data, input int last);
        exp_data.push_back(data);
        exp_last.push_back(last);
    endfunction

    function automatic int max4(input int a, input int b, input int c, input int d);
        int m;
        m = a;
        if (b > m) begin
            m = b;
        end
        if (c > m) begin
            m = c;
        end
        if (d > m) begin
            m = d;
        end
        return m;
    endfunction

    function automatic int is_last_pool(input int py, input int px);
        return (py == `CNN_IMG_H / 2 - 1) && (px == `CNN_IMG_W / 2 - 1);
    endfunction

    // with the identity kernel each pooled byte is the max of the raw 2x2 block
    function automatic void expect_block_max();
        for (int py = 0; py < `CNN_IMG_H / 2; py++) begin
            for (int px = 0; px < `CNN_IMG_W / 2; px++) begin
                push_expected(max4(pixel_at(2 * py, 2 * px), pixel_at(2 * py, 2 * px + 1),
                                   pixel_at(2 * py + 1, 2 * px),
                                   pixel_at(2 * py + 1, 2 * px + 1)),
                              is_last_pool(py, px));
            end
        end
    endfunction

    function automatic void expect_constant(input int value);
        for (int py = 0; py < `CNN_IMG_H / 2; py++) begin
            for (int px = 0; px < `CNN_IMG_W / 2; px++) begin
                push_expected(value, is_last_pool(py, px));
            end
        end
    endfunction

    // conv, bias, scale, shift, clamp, then 2x2 max-pool
    function automatic void ref_frame();
        longint acc;
        longint bias_v;
        longint scale_v;
        longint v;
        int     qmap [`CNN_IMG_H][`CNN_IMG_W];
        bias_v  = longint'($signed({prm[9], prm[10], prm[11]}));
        scale_v = {32'h0, prm[12], prm[13], prm[14], prm[15]};
        for (int y = 0; y < `CNN_IMG_H; y++) begin
            for (int x = 0; x < `CNN_IMG_W; x++) begin
                acc = 0;
                for (int r = 0; r < 3; r++) begin
                    for (int c = 0; c < 3; c++) begin
                        acc += longint'($signed(prm[3 * r + c])) *
                               longint'(pixel_at(y - 1 + r, x - 1 + c));
                    end
                end
                v = ((acc + bias_v) * scale_v) >>> `CNN_QUANT_SHIFT;
                qmap[y][x] = (v < 0) ? 0 : (v > 255) ? 255 : int'(v);
            end
        end
        for (int py = 0; py < `CNN_IMG_H / 2; py++) begin
            for (int px = 0; px < `CNN_IMG_W / 2; px++) begin
                push_expected(max4(qmap[2 * py][2 * px], qmap[2 * py][2 * px + 1],
                                   qmap[2 * py + 1][2 * px], qmap[2 * py + 1][2 * px + 1]),
                              is_last_pool(py, px));
            end
        end
    endfunction

    task automatic set_bias_scale(input int bias_v, input logic [31:0] scale_v);
        prm[9]  = bias_v[23:16];
        prm[10] = bias_v[15:8];
        prm[11] = bias_v[7:0];
        prm[12] = scale_v[31:24];
        prm[13] = scale_v[23:16];
        prm[14] = scale_v[15:8];
        prm[15] = scale_v[7:0];
    endtask

    task automatic random_weights();
        for (int i = 0; i < 9; i++) begin
            prm[i] = $random(seed);
        end
    endtask

    task automatic fill_pixels(input logic [7:0] or_mask);
        for (int i = 0; i < NPIX; i++) begin
            img[i] = $random(seed) | or_mask;
        end
    endtask

    task automatic random_frame();
        random_weights();
        set_bias_scale($random(seed) % 4096, ($random(seed) & 32'h1ff) + 1);
        fill_pixels(8'h00);
    endtask

    task automatic queue_frame();
        for (int i = 0; i < `CNN_PARAM_BYTES; i++) begin
            src_q.push_back(prm[i]);
        end
        for (int i = 0; i < NPIX; i++) begin
            src_q.push_back(img[i]);
        end
    endtask

    task automatic start_test(input string name);
        @(posedge clk_top);
        cur_test    = name;
        err_start   = errors;
        lasts_start = lasts_seen;
    endtask

    task automatic finish_test(input int frames);
        while (exp_data.size() != 0 || src_q.size() != 0) begin
            @(posedge clk_top);
        end
        check_value("frames closed", frames, lasts_seen - lasts_start);
        tests_run++;
        if (errors == err_start) begin
            $display("test %s: pass", cur_test);
        end else begin
            tests_failed++;
            $display("test %s: FAIL with %0d errors", cur_test, errors - err_start);
        end
    endtask

    // source spends one credit per byte and gets one back per in_credit
    initial begin
        src_credits = `CNN_IN_DEPTH;
        in_valid    = 1'b0;
        in_data     = '0;
        @(posedge rst_n);
        forever begin
            @(negedge clk_top);
            if (in_credit) begin
                src_credits++;
            end
            if (src_credits > `CNN_IN_DEPTH) begin
                flag_error("DUT returned more input credits than bytes sent");
            end
            in_valid = 1'b0;
            if (src_credits != 0 && src_q.size() != 0) begin
                in_data  = src_q.pop_front();
                in_valid = 1'b1;
                src_credits--;
            end
        end
    end

    // sink keeps its open credits full or grants them one at a time
    initial begin
        out_credit = 1'b0;
        sink_open  = 0;
        gap        = 0;
        @(posedge rst_n);
        forever begin
            @(negedge clk_top);
            out_credit = 1'b0;
            if (out_valid) begin
                if (sink_open == 0) begin
                    flag_error("out_valid without an open output credit");
                end else begin
                    sink_open--;
                end
            end
            if (slow_sink) begin
                if (sink_open == 0 && gap == 0) begin
                    out_credit = 1'b1;
                    sink_open++;
                    gap = $random(seed) & 7;
                end else if (sink_open == 0) begin
                    gap--;
                end
            end else if (sink_open < `CNN_OUT_CREDITS_MAX) begin
                out_credit = 1'b1;
                sink_open++;
            end
        end
    end

    // compare each pooled byte in order
    initial begin
        lasts_seen = 0;
        @(posedge rst_n);
        forever begin
            @(negedge clk_top);
            if (out_valid) begin
                if (out_last) begin
                    lasts_seen++;
                end
                if (exp_data.size() == 0) begin
                    flag_error("output byte arrived with nothing expected");
                end else begin
                    check_value("data", exp_data.pop_front(), out_data);
                    check_value("last", exp_last.pop_front(), out_last);
                end
            end else if (out_last) begin
                flag_error("out_last raised without out_valid");
            end
        end
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge clk_top);
            cycle_count++;
        end
        $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("Something failed");
        $finish;
    end

    initial begin
        clk_top      = 1'b0;
        rst_n        = 1'b0;
        seed         = 32'h6157049e;
        cur_test     = "reset";
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        slow_sink    = 1'b0;
        repeat (8) @(posedge clk_top);
        @(negedge clk_top);
        rst_n = 1'b1;

        start_test("identity");
        for (int i = 0; i < 9; i++) begin
            prm[i] = 8'h00;
        end
        prm[4] = 8'h01;
        set_bias_scale(0, 32'h0001_0000);
        fill_pixels(8'h00);
        queue_frame();
        expect_block_max();
        finish_test(1);

        start_test("random");
        random_frame();
        queue_frame();
        ref_frame();
        finish_test(1);

        // every window holds a centre of 128 or more
        start_test("saturation");
        for (int i = 0; i < 9; i++) begin
            prm[i] = 8'd127;
        end
        set_bias_scale(0, 32'h0001_0000);
        fill_pixels(8'h80);
        queue_frame();
        expect_constant(255);
        random_weights();
        set_bias_scale(-8388608, 32'h0001_0000);
        fill_pixels(8'h00);
        queue_frame();
        expect_constant(0);
        finish_test(2);

        start_test("back_pressure");
        slow_sink = 1'b1;
        random_frame();
        queue_frame();
        ref_frame();
        finish_test(1);
        slow_sink = 1'b0;

        start_test("two_frames");
        random_frame();
        queue_frame();
        ref_frame();
        random_frame();
        queue_frame();
        ref_frame();
        finish_test(2);

        $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed,
                 errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+include
rtl/cnn_pkg.sv
rtl/ingress_fifo.sv
rtl/param_loader.sv
rtl/line_window.sv
rtl/conv_mac.sv
rtl/quantizer.sv
rtl/maxpool_2x2.sv
rtl/cnn_top.sv
testbench/tb_cnn_top.sv
